/* common/cmd_apb_pkg.sv */
`default_nettype none

package cmd_apb_pkg;

  // Register and APB data word
  typedef logic [15:0] data_t;

  // APB address, logical unit on top of the command address
  typedef logic [31:0] paddr_t;

  typedef logic [3:0] lun_t;
  typedef logic [27:0] cmd_adr_t;

  // Request word: write flag, paddr, wdata
  localparam int REQ_W = 49;

  // Response word: error flag, write flag, rdata
  localparam int RSP_W = 18;

  // FIFO depth is 2**FIFO_ABITS
  localparam int FIFO_ABITS = 2;

  // Registers in the APB target
  localparam int REG_COUNT = 16;

  // Command-side FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DONE
  } bridge_state_e;

  // APB transfer phases
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_phase_e;

endpackage

`default_nettype wire

/* common/apb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface apb_if;

  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [1:0]          pstrb;
  cmd_apb_pkg::paddr_t paddr;
  cmd_apb_pkg::data_t  pwdata;
  logic                pready;
  cmd_apb_pkg::data_t  prdata;
  logic                pslverr;

  // Bridge side
  modport requester (
    output psel, penable, pwrite, pstrb, paddr, pwdata,
    input  pready, prdata, pslverr
  );

  // Register target side
  modport completer (
    input  psel, penable, pwrite, pstrb, paddr, pwdata,
    output pready, prdata, pslverr
  );

endinterface

`default_nettype wire

/* async_fifo/async_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
  parameter int WIDTH = 8,
  parameter int ABITS = 2
) (
  input  wire logic             areset_n,

  input  wire logic             wr_clk_i,
  input  wire logic             wr_valid_i,
  output logic                  wr_ready_o,
  input  wire logic [WIDTH-1:0] wr_data_i,

  input  wire logic             rd_clk_i,
  output logic                  rd_valid_o,
  input  wire logic             rd_ready_i,
  output logic [WIDTH-1:0]      rd_data_o
);

  localparam int DEPTH = 1 << ABITS;

  logic [WIDTH-1:0] mem [DEPTH];

  // One extra pointer bit tells full from empty
  logic [ABITS:0] wr_bin;
  logic [ABITS:0] wr_bin_next;
  logic [ABITS:0] wr_gray;
  logic [ABITS:0] rd_bin;
  logic [ABITS:0] rd_bin_next;
  logic [ABITS:0] rd_gray;

  // Synchronizer stages for the opposite pointer
  logic [ABITS:0] rd_gray_w1;
  logic [ABITS:0] rd_gray_w2;
  logic [ABITS:0] wr_gray_r1;
  logic [ABITS:0] wr_gray_r2;

  logic wr_fire;
  logic rd_fire;

  assign wr_fire     = wr_valid_i && wr_ready_o;
  assign rd_fire     = rd_valid_o && rd_ready_i;
  assign wr_bin_next = wr_bin + 1'b1;
  assign rd_bin_next = rd_bin + 1'b1;

  // Full when the top two gray bits differ and the rest match
  assign wr_ready_o = (wr_gray !=
                       {~rd_gray_w2[ABITS:ABITS-1], rd_gray_w2[ABITS-2:0]});
  assign rd_valid_o = (rd_gray != wr_gray_r2);

  // First-word fall-through read
  assign rd_data_o = mem[rd_bin[ABITS-1:0]];

  always_ff @(posedge wr_clk_i) begin
    if (wr_fire) begin
      mem[wr_bin[ABITS-1:0]] <= wr_data_i;
    end
  end

  // Write domain
  always_ff @(posedge wr_clk_i or negedge areset_n) begin
    if (!areset_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end else begin
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
      if (wr_fire) begin
        wr_bin  <= wr_bin_next;
        wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
      end
    end
  end

  // Read domain
  always_ff @(posedge rd_clk_i or negedge areset_n) begin
    if (!areset_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end else begin
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
      if (rd_fire) begin
        rd_bin  <= rd_bin_next;
        rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cmd_to_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_to_apb (
  input  wire logic                  areset_n,
  input  wire logic                  cmd_clk,
  input  wire logic                  pclk,

  // Host command port, cmd_clk domain
  input  wire logic                  cmd_vld_i,
  input  wire logic                  cmd_ack_i,
  input  wire logic                  cmd_dir_i,
  input  wire cmd_apb_pkg::lun_t     cmd_lun_i,
  input  wire cmd_apb_pkg::cmd_adr_t cmd_adr_i,
  input  wire cmd_apb_pkg::data_t    cmd_val_i,
  output logic                       cmd_rdy_o,
  output logic                       cmd_err_o,
  output cmd_apb_pkg::data_t         cmd_val_o,

  apb_if.requester                   apb
);

  cmd_apb_pkg::bridge_state_e state_q;
  cmd_apb_pkg::apb_phase_e    phase_q;

  logic                          req_wr_valid;
  logic                          req_wr_ready;
  logic [cmd_apb_pkg::REQ_W-1:0] req_wr_data;
  logic                          req_rd_valid;
  logic                          req_rd_ready;
  logic [cmd_apb_pkg::REQ_W-1:0] req_rd_data;

  logic                          rsp_wr_valid;
  logic                          rsp_wr_ready;
  logic [cmd_apb_pkg::RSP_W-1:0] rsp_wr_data;
  logic                          rsp_rd_valid;
  logic                          rsp_rd_ready;
  logic [cmd_apb_pkg::RSP_W-1:0] rsp_rd_data;

  logic                          dir_q;
  logic                          rsp_error;
  logic                          rsp_write;
  cmd_apb_pkg::data_t            rsp_rdata;
  logic                          req_write;
  logic                          xfer_done;

  // Command domain

  // Direction 1 is a read, so the write flag is its inverse
  assign req_wr_data  = {~cmd_dir_i, cmd_lun_i, cmd_adr_i, cmd_val_i};
  assign req_wr_valid = (state_q == cmd_apb_pkg::ST_IDLE) && cmd_vld_i && !cmd_err_o;
  assign rsp_rd_ready = (state_q == cmd_apb_pkg::ST_WAIT);

  assign {rsp_error, rsp_write, rsp_rdata} = rsp_rd_data;

  always_ff @(posedge cmd_clk or negedge areset_n) begin
    if (!areset_n) begin
      state_q   <= cmd_apb_pkg::ST_IDLE;
      cmd_rdy_o <= 1'b0;
      cmd_err_o <= 1'b0;
    end else begin
      cmd_rdy_o <= 1'b0;
      if (cmd_ack_i) begin
        cmd_err_o <= 1'b0;
      end
      case (state_q)
        cmd_apb_pkg::ST_IDLE: begin
          // Stays here while the request FIFO is full
          if (req_wr_valid && req_wr_ready) begin
            state_q <= cmd_apb_pkg::ST_WAIT;
          end
        end
        cmd_apb_pkg::ST_WAIT: begin
          if (rsp_rd_valid) begin
            if (rsp_error || (rsp_write == dir_q)) begin
              cmd_err_o <= 1'b1;
            end else begin
              cmd_rdy_o <= 1'b1;
            end
            state_q <= cmd_apb_pkg::ST_DONE;
          end
        end
        cmd_apb_pkg::ST_DONE: begin
          // Host must drop valid before the next command
          if (!cmd_vld_i) begin
            state_q <= cmd_apb_pkg::ST_IDLE;
          end
        end
        default: state_q <= cmd_apb_pkg::ST_IDLE;
      endcase
    end
  end

  // Direction and read data of the outstanding command
  always_ff @(posedge cmd_clk) begin
    if (req_wr_valid && req_wr_ready) begin
      dir_q <= cmd_dir_i;
    end
    if (rsp_rd_valid && rsp_rd_ready) begin
      cmd_val_o <= rsp_rdata;
    end
  end

  async_fifo #(
    .WIDTH (cmd_apb_pkg::REQ_W),
    .ABITS (cmd_apb_pkg::FIFO_ABITS)
  ) u_req_fifo (
    .areset_n   (areset_n),
    .wr_clk_i   (cmd_clk),
    .wr_valid_i (req_wr_valid),
    .wr_ready_o (req_wr_ready),
    .wr_data_i  (req_wr_data),
    .rd_clk_i   (pclk),
    .rd_valid_o (req_rd_valid),
    .rd_ready_i (req_rd_ready),
    .rd_data_o  (req_rd_data)
  );

  async_fifo #(
    .WIDTH (cmd_apb_pkg::RSP_W),
    .ABITS (cmd_apb_pkg::FIFO_ABITS)
  ) u_rsp_fifo (
    .areset_n   (areset_n),
    .wr_clk_i   (pclk),
    .wr_valid_i (rsp_wr_valid),
    .wr_ready_o (rsp_wr_ready),
    .wr_data_i  (rsp_wr_data),
    .rd_clk_i   (cmd_clk),
    .rd_valid_o (rsp_rd_valid),
    .rd_ready_i (rsp_rd_ready),
    .rd_data_o  (rsp_rd_data)
  );

  // APB domain

  // Request word stays at the FIFO head for the whole transfer
  assign {req_write, apb.paddr, apb.pwdata} = req_rd_data;

  assign apb.pwrite  = req_write;
  assign apb.pstrb   = {req_write, req_write};
  assign apb.psel    = (phase_q != cmd_apb_pkg::APB_IDLE);
  assign apb.penable = (phase_q == cmd_apb_pkg::APB_ACCESS);

  assign xfer_done    = (phase_q == cmd_apb_pkg::APB_ACCESS) && apb.pready;
  assign req_rd_ready = xfer_done;
  assign rsp_wr_valid = xfer_done;
  assign rsp_wr_data  = {apb.pslverr, req_write, apb.prdata};

  always_ff @(posedge pclk or negedge areset_n) begin
    if (!areset_n) begin
      phase_q <= cmd_apb_pkg::APB_IDLE;
    end else begin
      case (phase_q)
        cmd_apb_pkg::APB_IDLE: begin
          // Room for the response is checked before starting
          if (req_rd_valid && rsp_wr_ready) begin
            phase_q <= cmd_apb_pkg::APB_SETUP;
          end
        end
        cmd_apb_pkg::APB_SETUP: phase_q <= cmd_apb_pkg::APB_ACCESS;
        cmd_apb_pkg::APB_ACCESS: begin
          if (apb.pready) begin
            phase_q <= cmd_apb_pkg::APB_IDLE;
          end
        end
        default: phase_q <= cmd_apb_pkg::APB_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/apb_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_regfile (
  input wire logic pclk,
  input wire logic areset_n,
  apb_if.completer apb
);

  cmd_apb_pkg::data_t regs [cmd_apb_pkg::REG_COUNT];

  logic [3:0] reg_idx;
  logic       out_of_range;
  logic       access;
  logic       wait_q;
  logic       wr_en;

  // Halfword registers, so bit 0 of the address is ignored
  assign reg_idx      = apb.paddr[4:1];
  assign out_of_range = |apb.paddr[31:5];
  assign access       = apb.psel && apb.penable;

  // First access cycle is the wait state
  assign apb.pready   = access && wait_q;
  assign apb.pslverr  = apb.pready && out_of_range;
  assign apb.prdata   = (apb.pready && !out_of_range) ? regs[reg_idx] : '0;

  assign wr_en = apb.pready && apb.pwrite && !out_of_range;

  always_ff @(posedge pclk or negedge areset_n) begin
    if (!areset_n) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access && !wait_q;
    end
  end

  always_ff @(posedge pclk or negedge areset_n) begin
    if (!areset_n) begin
      for (int i = 0; i < cmd_apb_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      // Byte lanes
      if (apb.pstrb[0]) begin
        regs[reg_idx][7:0] <= apb.pwdata[7:0];
      end
      if (apb.pstrb[1]) begin
        regs[reg_idx][15:8] <= apb.pwdata[15:8];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cmd_apb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_apb_top (
  input  wire logic                  areset_n,
  input  wire logic                  cmd_clk,
  input  wire logic                  pclk,

  input  wire logic                  cmd_vld_i,
  input  wire logic                  cmd_ack_i,
  input  wire logic                  cmd_dir_i,
  input  wire cmd_apb_pkg::lun_t     cmd_lun_i,
  input  wire cmd_apb_pkg::cmd_adr_t cmd_adr_i,
  input  wire cmd_apb_pkg::data_t    cmd_val_i,
  output logic                       cmd_rdy_o,
  output logic                       cmd_err_o,
  output cmd_apb_pkg::data_t         cmd_val_o
);

  // APB bus in the pclk domain
  apb_if apb_bus ();

  cmd_to_apb u_bridge (
    .areset_n  (areset_n),
    .cmd_clk   (cmd_clk),
    .pclk      (pclk),
    .cmd_vld_i (cmd_vld_i),
    .cmd_ack_i (cmd_ack_i),
    .cmd_dir_i (cmd_dir_i),
    .cmd_lun_i (cmd_lun_i),
    .cmd_adr_i (cmd_adr_i),
    .cmd_val_i (cmd_val_i),
    .cmd_rdy_o (cmd_rdy_o),
    .cmd_err_o (cmd_err_o),
    .cmd_val_o (cmd_val_o),
    .apb       (apb_bus.requester)
  );

  apb_regfile u_regs (
    .pclk     (pclk),
    .areset_n (areset_n),
    .apb      (apb_bus.completer)
  );

endmodule

`default_nettype wire

/* verification/cmd_apb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_apb_checker (
  input  wire logic                  cmd_clk,
  input  wire logic                  areset_n,
  input  wire logic                  cmd_vld_i,
  input  wire logic                  cmd_ack_i,
  input  wire logic                  cmd_dir_i,
  input  wire cmd_apb_pkg::lun_t     cmd_lun_i,
  input  wire cmd_apb_pkg::cmd_adr_t cmd_adr_i,
  input  wire cmd_apb_pkg::data_t    cmd_val_i,
  input  wire logic                  cmd_rdy_i,
  input  wire logic                  cmd_err_i,
  input  wire cmd_apb_pkg::data_t    cmd_rval_i,
  output int                         fail_count_o,
  output int                         check_count_o,
  output int                         write_count_o
);

  // Register model, indexed like the target
  cmd_apb_pkg::data_t model [cmd_apb_pkg::REG_COUNT];

  cmd_apb_pkg::lun_t     cur_lun;
  cmd_apb_pkg::cmd_adr_t cur_adr;
  cmd_apb_pkg::data_t    cur_val;
  logic                  cur_dir;
  logic                  err_q;
  logic                  ack_q;
  logic                  exp_err;
  logic [3:0]            idx;

  initial begin
    for (int i = 0; i < cmd_apb_pkg::REG_COUNT; i++) begin
      model[i] = '0;
    end
    fail_count_o  = 0;
    check_count_o = 0;
    write_count_o = 0;
    cur_dir       = 1'b1;
    cur_lun       = '0;
    cur_adr       = '0;
    cur_val       = '0;
    err_q         = 1'b0;
    ack_q         = 1'b0;
  end

  always @(posedge cmd_clk) begin
    if (!areset_n) begin
      if (cmd_rdy_i || cmd_err_i) begin
        $display("FAIL %0t: ready or error active during reset", $time);
        fail_count_o++;
      end
    end else begin
      // Lun zero and address bits 27:5 zero are in range
      exp_err = (cur_lun != '0) || (|cur_adr[27:5]);
      idx     = cur_adr[4:1];
      if (cmd_rdy_i) begin
        check_count_o++;
        if (exp_err) begin
          $display("FAIL %0t: out-of-range command lun %0d adr %h gave ready",
                   $time, cur_lun, cur_adr);
          fail_count_o++;
        end else if (cur_dir) begin
          if (cmd_rval_i !== model[idx]) begin
            $display("FAIL %0t: read of reg %0d returned %h, expected %h",
                     $time, idx, cmd_rval_i, model[idx]);
            fail_count_o++;
          end
        end else begin
          model[idx] = cur_val;
          write_count_o++;
        end
      end
      if (cmd_err_i && !err_q) begin
        check_count_o++;
        if (!exp_err) begin
          $display("FAIL %0t: in-range command lun %0d adr %h gave error",
                   $time, cur_lun, cur_adr);
          fail_count_o++;
        end
      end
      if (err_q && !cmd_err_i && !ack_q) begin
        $display("FAIL %0t: error cleared without acknowledge", $time);
        fail_count_o++;
      end
      // Host keeps the command stable while valid is high
      if (cmd_vld_i) begin
        cur_dir = cmd_dir_i;
        cur_lun = cmd_lun_i;
        cur_adr = cmd_adr_i;
        cur_val = cmd_val_i;
      end
    end
    err_q = cmd_err_i;
    ack_q = cmd_ack_i;
  end

endmodule

`default_nettype wire

/* verification/tb_cmd_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_apb;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_CMDS    = 300;

  logic                  cmd_clk = 1'b0;
  logic                  pclk = 1'b0;
  logic                  areset_n = 1'b0;
  logic                  cmd_vld = 1'b0;
  logic                  cmd_ack = 1'b0;
  logic                  cmd_dir = 1'b0;
  cmd_apb_pkg::lun_t     cmd_lun = '0;
  cmd_apb_pkg::cmd_adr_t cmd_adr = '0;
  cmd_apb_pkg::data_t    cmd_val = '0;
  logic                  cmd_rdy;
  logic                  cmd_err;
  cmd_apb_pkg::data_t    cmd_rval;

  int fail_count;
  int check_count;
  int write_count;
  int tb_errors = 0;
  int done_count = 0;
  int cmd_count = 0;
  int errors_before = 0;

  logic [31:0]           lcg_state = 32'ha94d;
  logic [31:0]           ctrl;
  logic [31:0]           data;
  cmd_apb_pkg::lun_t     r_lun;
  cmd_apb_pkg::cmd_adr_t r_adr;

  always #2 cmd_clk = ~cmd_clk;

  // Slower APB clock so the FIFOs really cross domains
  always #3 pclk = ~pclk;

  cmd_apb_top dut (
    .areset_n  (areset_n),
    .cmd_clk   (cmd_clk),
    .pclk      (pclk),
    .cmd_vld_i (cmd_vld),
    .cmd_ack_i (cmd_ack),
    .cmd_dir_i (cmd_dir),
    .cmd_lun_i (cmd_lun),
    .cmd_adr_i (cmd_adr),
    .cmd_val_i (cmd_val),
    .cmd_rdy_o (cmd_rdy),
    .cmd_err_o (cmd_err),
    .cmd_val_o (cmd_rval)
  );

  cmd_apb_checker u_checker (
    .cmd_clk       (cmd_clk),
    .areset_n      (areset_n),
    .cmd_vld_i     (cmd_vld),
    .cmd_ack_i     (cmd_ack),
    .cmd_dir_i     (cmd_dir),
    .cmd_lun_i     (cmd_lun),
    .cmd_adr_i     (cmd_adr),
    .cmd_val_i     (cmd_val),
    .cmd_rdy_i     (cmd_rdy),
    .cmd_err_i     (cmd_err),
    .cmd_rval_i    (cmd_rval),
    .fail_count_o  (fail_count),
    .check_count_o (check_count),
    .write_count_o (write_count)
  );

  function automatic logic [31:0] draw_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic clear_error();
    int cycles;
    // Error has to hold for a while before the acknowledge
    repeat (2) @(negedge cmd_clk);
    cmd_ack = 1'b1;
    @(negedge cmd_clk);
    cmd_ack = 1'b0;
    cycles = 0;
    while (cmd_err && cycles < TIMEOUT_CYCLES) begin
      @(negedge cmd_clk);
      cycles++;
    end
    if (cmd_err) begin
      $display("Error flag did not clear after acknowledge at %0t", $time);
      tb_errors++;
    end
  endtask

  task automatic run_cmd(input logic dir, input cmd_apb_pkg::lun_t lun,
                         input cmd_apb_pkg::cmd_adr_t adr, input cmd_apb_pkg::data_t val);
    int   cycles;
    logic done;
    @(negedge cmd_clk);
    cmd_dir = dir;
    cmd_lun = lun;
    cmd_adr = adr;
    cmd_val = val;
    cmd_vld = 1'b1;
    cmd_count++;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge cmd_clk);
      cycles++;
      done = cmd_rdy || cmd_err;
    end
    cmd_vld = 1'b0;
    if (!done) begin
      $display("Command to lun %0d address %h never completed (%0t)", lun, adr, $time);
      tb_errors++;
    end else begin
      done_count++;
      if (cmd_err) begin
        clear_error();
      end
    end
    // Valid low for a cycle separates commands
    @(negedge cmd_clk);
  endtask

  task automatic report_test(input int num, input string name);
    int errs;
    errs = fail_count + tb_errors - errors_before;
    if (errs == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errs);
    end
    errors_before = fail_count + tb_errors;
  endtask

  initial begin
    repeat (16) @(posedge cmd_clk);
    @(negedge cmd_clk);
    areset_n = 1'b1;

    // Test 1: idle outputs and all registers zero
    @(negedge cmd_clk);
    if (cmd_rdy !== 1'b0 || cmd_err !== 1'b0) begin
      $display("FAIL %0t: ready or error not low after reset", $time);
      tb_errors++;
    end
    for (int i = 0; i < cmd_apb_pkg::REG_COUNT; i++) begin
      run_cmd(1'b1, '0, cmd_apb_pkg::cmd_adr_t'(i << 1), '0);
    end
    report_test(1, "reset state");

    // Test 2: write, read back, then disturb the neighbours
    run_cmd(1'b0, '0, 28'h00a, 16'h5a3c);
    run_cmd(1'b1, '0, 28'h00a, '0);
    for (int i = 0; i < cmd_apb_pkg::REG_COUNT; i++) begin
      if (i != 5) begin
        data = draw_random();
        run_cmd(1'b0, '0, cmd_apb_pkg::cmd_adr_t'((i << 1) | 1), data[31:16]);
      end
    end
    for (int i = 0; i < cmd_apb_pkg::REG_COUNT; i++) begin
      run_cmd(1'b1, '0, cmd_apb_pkg::cmd_adr_t'(i << 1), '0);
    end
    report_test(2, "write and read back");

    // Test 3: out-of-range accesses that alias register 9
    run_cmd(1'b0, '0, 28'h012, 16'hc0de);
    run_cmd(1'b0, 4'h1, 28'h012, 16'hffff);
    run_cmd(1'b0, '0, 28'h032, 16'h1234);
    run_cmd(1'b1, 4'h3, 28'h012, '0);
    run_cmd(1'b1, '0, 28'h8000012, '0);
    run_cmd(1'b1, '0, 28'h012, '0);
    report_test(3, "range errors");

    // Test 4: normal traffic right after an acknowledged error
    run_cmd(1'b0, 4'hf, 28'h004, 16'h0bad);
    run_cmd(1'b0, '0, 28'h004, 16'h7e11);
    run_cmd(1'b1, '0, 28'h004, '0);
    report_test(4, "recovery after error");

    // Test 5: random mix, about one in eight out of range
    for (int n = 0; n < RANDOM_CMDS; n++) begin
      ctrl  = draw_random();
      data  = draw_random();
      r_lun = '0;
      r_adr = cmd_apb_pkg::cmd_adr_t'(ctrl[30:26]);
      if (ctrl[25:23] == 3'd0) begin
        if (ctrl[22]) begin
          r_lun = ctrl[21:18] | 4'h1;
        end else begin
          r_adr[5 + (ctrl[20:16] % 23)] = 1'b1;
        end
      end
      run_cmd(ctrl[31], r_lun, r_adr, data[31:16]);
    end
    report_test(5, "random commands");

    if (check_count != done_count) begin
      $display("Checker saw %0d completions, testbench saw %0d", check_count, done_count);
      tb_errors++;
    end
    $display("commands %0d, checks %0d, register writes %0d, errors %0d",
             cmd_count, check_count, write_count, fail_count + tb_errors);
    if (fail_count + tb_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
common/cmd_apb_pkg.sv
common/apb_if.sv
async_fifo/async_fifo.sv
logic/cmd_to_apb.sv
logic/apb_regfile.sv
logic/cmd_apb_top.sv
verification/cmd_apb_checker.sv
verification/tb_cmd_apb.sv
